// File: Bender.yml
package:
  name: assoc_cache

sources:
  # packages first, cache_types refers to mem_port_types
  - rtl/mem_port_types.sv
  - rtl/cache_types.sv
  - rtl/sram_array.sv
  - rtl/line_state_array.sv
  - rtl/lru_array.sv
  - rtl/lru_ctrl.sv
  - rtl/cache.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/tb_cache.sv

// File: project.f
rtl/mem_port_types.sv
rtl/cache_types.sv
rtl/sram_array.sv
rtl/line_state_array.sv
rtl/lru_array.sv
rtl/lru_ctrl.sv
rtl/cache.sv
sim/mem_model.sv
sim/tb_cache.sv

// File: rtl/cache.sv
`timescale 1ns/1ns

module cache #(
    parameter int sets = 16
) (
    input  logic                        clk,
    input  logic                        reset,

    // cpu side
    input  mem_port_types::ufp_req_t    ufp_req,
    output logic [31:0]                 ufp_rdata,
    output logic                        ufp_resp,

    // memory side
    output mem_port_types::dfp_req_t    dfp_req,
    input  cache_types::line_t          dfp_rdata,
    input  logic                        dfp_resp
);

    import cache_types::*;
    import mem_port_types::*;

    localparam int set_bits    = $clog2(sets);
    localparam int offset_bits = $clog2(line_bytes);

    if (set_bits > max_set_bits || (2 ** set_bits) != sets) begin : g_sets_check
        $error("cache: sets must be a power of two within the stage set field");
    end

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_fill,
        st_replay
    } fsm_state_t;

    fsm_state_t state;
    fsm_state_t state_next;

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////

    logic                req_valid;
    logic                decode;
    logic [set_bits-1:0] dec_set;

    assign req_valid = (|ufp_req.rmask) || (|ufp_req.wmask);
    // only one item in flight, so decode waits for an idle lookup stage
    assign decode    = (state == st_idle) && req_valid;
    assign dec_set   = ufp_req.addr[offset_bits +: set_bits];

    stage_reg_t          stage;
    tag_t                stg_tag;
    logic [set_bits-1:0] stg_set;
    plru_t               lru_rdata;

    always_ff @(posedge clk) begin
        if (decode) begin
            stage.req    <= ufp_req;
            stage.set    <= set_idx_t'(dec_set);
            stage.offset <= ufp_req.addr[4:2];
            stage.plru   <= lru_rdata;
        end
    end

    assign stg_tag = stage.req.addr[31:offset_bits];
    assign stg_set = stage.set[set_bits-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // arrays
    ////////////////////////////////////////////////////////////////////////////

    logic                arr_rd;
    logic [set_bits-1:0] arr_addr;
    logic [ways-1:0]     way_we;
    logic [31:0]         data_wmask;
    line_t               data_din;
    line_state_t         ls_din;
    logic                fill_write;

    line_t               data_dout [ways];
    tag_t                tag_dout  [ways];
    line_state_t         ls_dout   [ways];

    // re-read on replay so the outputs show the filled line
    assign arr_rd     = decode || (state == st_replay);
    assign arr_addr   = decode ? dec_set : stg_set;
    assign fill_write = (state == st_fill) && dfp_resp;

    always_comb begin
        data_wmask = '0;
        data_din   = {8{stage.req.wdata}};
        ls_din     = '{valid: 1'b1, dirty: 1'b1};
        if (fill_write) begin
            data_wmask = '1;
            data_din   = dfp_rdata;
            ls_din     = '{valid: 1'b1, dirty: 1'b0};
        end else begin
            data_wmask[4*stage.offset +: 4] = stage.req.wmask;
        end
    end

    for (genvar i = 0; i < ways; i++) begin : g_way
        sram_array #(
            .depth     (sets),
            .payload_t (line_t)
        ) u_data (
            .clk   (clk),
            .en    (arr_rd || way_we[i]),
            .we    (way_we[i]),
            .wmask (data_wmask),
            .addr  (arr_addr),
            .din   (data_din),
            .dout  (data_dout[i])
        );

        // tag rewrite on a write hit stores the same value
        sram_array #(
            .depth     (sets),
            .payload_t (tag_t)
        ) u_tag (
            .clk   (clk),
            .en    (arr_rd || way_we[i]),
            .we    (way_we[i]),
            .wmask ('1),
            .addr  (arr_addr),
            .din   (stg_tag),
            .dout  (tag_dout[i])
        );

        line_state_array #(
            .depth (sets)
        ) u_state (
            .clk   (clk),
            .reset (reset),
            .en    (arr_rd || way_we[i]),
            .we    (way_we[i]),
            .addr  (arr_addr),
            .din   (ls_din),
            .dout  (ls_dout[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    logic [ways-1:0] way_hit;
    logic            hit;
    logic            lookup_hit;
    way_idx_t        hit_idx;
    way_idx_t        victim;
    plru_t           plru_next;
    logic            victim_dirty;
    logic [31:0]     hit_word;

    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < ways; i++) begin
            way_hit[i] = ls_dout[i].valid && (tag_dout[i] == stg_tag);
            if (way_hit[i]) begin
                hit_idx = way_idx_t'(i);
            end
        end
    end

    assign hit          = |way_hit;
    assign lookup_hit   = (state == st_lookup) && hit;
    assign victim_dirty = ls_dout[victim].valid && ls_dout[victim].dirty;

    // write hit merges bytes, fill replaces the victim
    always_comb begin
        way_we = '0;
        if (lookup_hit && (|stage.req.wmask)) begin
            way_we[hit_idx] = 1'b1;
        end
        if (fill_write) begin
            way_we[victim] = 1'b1;
        end
    end

    always_comb begin
        hit_word = data_dout[hit_idx][32*stage.offset +: 32];
        for (int b = 0; b < 4; b++) begin
            ufp_rdata[8*b +: 8] = stage.req.rmask[b] ? hit_word[8*b +: 8] : 8'h00;
        end
    end

    assign ufp_resp = lookup_hit;

    lru_ctrl u_lru_ctrl (
        .plru      (stage.plru),
        .hit_way   (hit_idx),
        .victim    (victim),
        .plru_next (plru_next)
    );

    // replay hit is the access that updates the tree
    lru_array #(
        .depth (sets)
    ) u_lru_array (
        .clk   (clk),
        .reset (reset),
        .ren   (arr_rd),
        .raddr (arr_addr),
        .rdata (lru_rdata),
        .we    (lookup_hit),
        .waddr (stg_set),
        .wdata (plru_next)
    );

    ////////////////////////////////////////////////////////////////////////////
    // miss fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            st_idle: begin
                if (decode) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                if (hit) begin
                    state_next = st_idle;
                end else if (victim_dirty) begin
                    state_next = st_write_back;
                end else begin
                    state_next = st_fill;
                end
            end
            st_write_back: begin
                if (dfp_resp) begin
                    state_next = st_fill;
                end
            end
            st_fill: begin
                if (dfp_resp) begin
                    state_next = st_replay;
                end
            end
            st_replay: begin
                state_next = st_lookup;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // victim outputs hold steady, writes do not disturb dout
    always_comb begin
        dfp_req.addr  = {stg_tag, {offset_bits{1'b0}}};
        dfp_req.read  = (state == st_fill);
        dfp_req.write = (state == st_write_back);
        dfp_req.wdata = data_dout[victim];
        if (state == st_write_back) begin
            dfp_req.addr = {tag_dout[victim], {offset_bits{1'b0}}};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_one_hit : assert property (
        @(posedge clk) disable iff (reset)
        (state == st_lookup) |-> $onehot0(way_hit)
    ) else $error("cache: more than one way hit, way_hit %b", way_hit);

    a_dfp_excl : assert property (
        @(posedge clk) disable iff (reset)
        !(dfp_req.read && dfp_req.write)
    ) else $error("cache: dfp read and write both high");

    // response only one cycle after a decode or a replay read
    a_resp_state : assert property (
        @(posedge clk) disable iff (reset)
        ufp_resp |-> (state == st_lookup) && $past(state inside {st_idle, st_replay})
    ) else $error("cache: ufp_resp outside lookup, state %0d", state);

endmodule

// File: rtl/cache_types.sv
package cache_types;

    ////////////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////////////

    // fixed at four, the plru tree below is three bits
    localparam int ways       = 4;
    localparam int line_bytes = 32;

    // widest set index the stage register can carry
    localparam int max_set_bits = 8;

    // full line address above the byte offset, independent of set count
    typedef logic [26:0]  tag_t;
    typedef logic [255:0] line_t;
    typedef logic [1:0]   way_idx_t;
    typedef logic [2:0]   word_sel_t;
    typedef logic [max_set_bits-1:0] set_idx_t;

    // tree pseudo-lru state
    // bit 0: 0 -> pair 0/1 older, 1 -> pair 2/3 older
    // bit 1: 0 -> way 0 older than way 1
    // bit 2: 0 -> way 2 older than way 3
    typedef logic [2:0] plru_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } line_state_t;

    // lookup stage register
    typedef struct packed {
        mem_port_types::ufp_req_t req;
        set_idx_t                 set;
        word_sel_t                offset;
        plru_t                    plru;
    } stage_reg_t;

endpackage

// File: rtl/line_state_array.sv
`timescale 1ns/1ns

module line_state_array #(
    parameter int depth = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        en,
    input  logic                        we,
    input  logic [$clog2(depth)-1:0]    addr,
    input  cache_types::line_state_t    din,
    output cache_types::line_state_t    dout
);

    import cache_types::*;

    line_state_t mem [depth];

    // every line invalid and clean out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
            dout <= '0;
        end else if (en) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

// File: rtl/lru_array.sv
`timescale 1ns/1ns

module lru_array #(
    parameter int depth = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ren,
    input  logic [$clog2(depth)-1:0]    raddr,
    output cache_types::plru_t          rdata,
    input  logic                        we,
    input  logic [$clog2(depth)-1:0]    waddr,
    input  cache_types::plru_t          wdata
);

    import cache_types::*;

    plru_t mem [depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read is captured by the stage register, bypass a same cycle write
    always_comb begin
        rdata = '0;
        if (ren) begin
            rdata = (we && (waddr == raddr)) ? wdata : mem[raddr];
        end
    end

endmodule

// File: rtl/lru_ctrl.sv
`timescale 1ns/1ns

module lru_ctrl (
    input  cache_types::plru_t      plru,
    input  cache_types::way_idx_t   hit_way,
    output cache_types::way_idx_t   victim,
    output cache_types::plru_t      plru_next
);

    import cache_types::*;

    // follow the older pointers down the tree
    always_comb begin
        if (!plru[0]) begin
            victim = plru[1] ? way_idx_t'(1) : way_idx_t'(0);
        end else begin
            victim = plru[2] ? way_idx_t'(3) : way_idx_t'(2);
        end
    end

    // point every bit on the accessed path away from it
    always_comb begin
        plru_next = plru;
        if (!hit_way[1]) begin
            plru_next[0] = 1'b1;
            plru_next[1] = ~hit_way[0];
        end else begin
            plru_next[0] = 1'b0;
            plru_next[2] = ~hit_way[0];
        end
    end

endmodule

// File: rtl/mem_port_types.sv
package mem_port_types;

    ////////////////////////////////////////////////////////////////////////////
    // cpu side word port
    ////////////////////////////////////////////////////////////////////////////

    // a request is present while either mask is nonzero
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } ufp_req_t;

    ////////////////////////////////////////////////////////////////////////////
    // memory side line port
    ////////////////////////////////////////////////////////////////////////////

    // held until dfp_resp, addr always line aligned
    typedef struct packed {
        logic [31:0]  addr;
        logic         read;
        logic         write;
        logic [255:0] wdata;
    } dfp_req_t;

endpackage

// File: rtl/sram_array.sv
`timescale 1ns/1ns

module sram_array #(
    parameter int  depth     = 16,
    parameter type payload_t = logic [31:0]
) (
    input  logic                                 clk,
    input  logic                                 en,
    input  logic                                 we,
    input  logic [($bits(payload_t)+7)/8-1:0]    wmask,
    input  logic [$clog2(depth)-1:0]             addr,
    input  payload_t                             din,
    output payload_t                             dout
);

    localparam int width     = $bits(payload_t);
    localparam int mask_bits = (width + 7) / 8;
    localparam int mem_bits  = mask_bits * 8;

    // storage rounded up to whole bytes
    logic [mem_bits-1:0] mem [depth];
    logic [mem_bits-1:0] din_wide;

    always_comb begin
        din_wide = '0;
        din_wide[width-1:0] = din;
    end

    // write leaves the registered output alone
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < mask_bits; i++) begin
                    if (wmask[i]) begin
                        mem[addr][8*i +: 8] <= din_wide[8*i +: 8];
                    end
                end
            end else begin
                dout <= payload_t'(mem[addr][width-1:0]);
            end
        end
    end

    // only matters when depth is not a power of two
    a_addr_range : assert property (
        @(posedge clk) en |-> (int'(addr) < depth)
    ) else $error("sram_array: addr %0h outside depth %0d", addr, depth);

endmodule

// File: sim/mem_model.sv
`timescale 1ns/1ns

module mem_model (
    input  logic                        clk,
    input  logic                        reset,
    input  mem_port_types::dfp_req_t    dfp_req,
    output cache_types::line_t          dfp_rdata,
    output logic                        dfp_resp,
    output logic                        fault
);

    import cache_types::*;
    import mem_port_types::*;

    localparam logic [7:0] lfsr_seed = 8'd85;
    localparam int         num_lines = 2048;

    // backing store for the low 64 KiB
    line_t      mem [num_lines];
    logic [7:0] lfsr_state;

    // fibonacci lfsr, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    initial begin : serve
        dfp_req_t    held;
        line_t       expected;
        logic [1:0]  rnd;
        logic [10:0] li;

        dfp_rdata  = '0;
        dfp_resp   = 1'b0;
        fault      = 1'b0;
        lfsr_state = lfsr_seed;
        for (int l = 0; l < num_lines; l++) begin
            for (int w = 0; w < 8; w++) begin
                mem[l][32*w +: 32] = (32'(l) * 32 + 32'(w) * 4) ^ 32'h5a5a_0000;
            end
        end

        forever begin
            @(negedge clk);
            if (!reset && (dfp_req.read || dfp_req.write)) begin
                held = dfp_req;
                li   = held.addr[15:5];
                assert (held.addr[31:16] == '0 && held.addr[4:0] == '0) else begin
                    $display("memory request at %h is outside the model or not line aligned",
                             held.addr);
                    fault = 1'b1;
                end

                // two bits give a latency of 1 to 4 cycles
                rnd = '0;
                for (int b = 0; b < 2; b++) begin
                    rnd        = {rnd[0], lfsr_state[7]};
                    lfsr_state = lfsr_next(lfsr_state);
                end
                repeat (int'(rnd)) @(posedge clk);
                @(posedge clk);
                #1;

                if (held.write) begin
                    for (int w = 0; w < 8; w++) begin
                        expected[32*w +: 32] = tb_cache.shadow[{li, 3'(w)}];
                    end
                    assert (tb_cache.dirty_line[li]) else begin
                        $display("write-back of line %h which holds no written data",
                                 held.addr);
                        fault = 1'b1;
                    end
                    assert (held.wdata == expected) else begin
                        $display("Error: dfp_req.wdata line %h got %h expected %h",
                                 held.addr, held.wdata, expected);
                        fault = 1'b1;
                    end
                    mem[li] = held.wdata;
                    tb_cache.dirty_line[li] = 1'b0;
                end else begin
                    dfp_rdata = mem[li];
                end
                dfp_resp = 1'b1;
                @(posedge clk);
                #1;
                dfp_resp = 1'b0;
            end
        end
    end

endmodule

// File: sim/tb_cache.sv
`timescale 1ns/1ns

module tb_cache;

    import cache_types::*;
    import mem_port_types::*;

    localparam int reset_cycles = 3;
    localparam int cycle_budget = 40;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
        logic        exp_hit;
    } stim_t;

    logic        clk;
    logic        reset;
    ufp_req_t    ufp_req;
    logic [31:0] ufp_rdata;
    logic        ufp_resp;
    dfp_req_t    dfp_req;
    line_t       dfp_rdata;
    logic        dfp_resp;
    logic        mem_fault;

    // shadow of the low 64 KiB that the memory model also reads
    logic [31:0] shadow [16384];
    logic        dirty_line [2048];

    stim_t stim_table [$];
    logic  table_loaded = 1'b0;

    cache #(
        .sets (16)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .ufp_req   (ufp_req),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_req   (dfp_req),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    mem_model u_mem (
        .clk       (clk),
        .reset     (reset),
        .dfp_req   (dfp_req),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp),
        .fault     (mem_fault)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic add_entry(input logic [31:0] addr, input logic [3:0] rmask,
                             input logic [3:0] wmask, input logic [31:0] wdata,
                             input logic exp_hit);
        stim_t entry;

        entry.addr    = addr;
        entry.rmask   = rmask;
        entry.wmask   = wmask;
        entry.wdata   = wdata;
        entry.exp_hit = exp_hit;
        stim_table.push_back(entry);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_table();
        // word reads and byte writes on one line of set 0
        add_entry(32'h0000_0000, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_0004, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_001c, 4'h3, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_0008, 4'h0, 4'hf, 32'hdead_beef, 1'b1);
        add_entry(32'h0000_0008, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_0010, 4'h0, 4'h5, 32'h1122_3344, 1'b1);
        add_entry(32'h0000_0010, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_0010, 4'h8, 4'h0, 32'h0000_0000, 1'b1);
        // tags A B C D of set 3 fill ways 0 2 1 3
        add_entry(32'h0000_0260, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_0260, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_0464, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_0668, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_086c, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_0270, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        // tag E replaces B
        add_entry(32'h0000_0a60, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_0264, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_0674, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_0878, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_0460, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        // dirty line in set 5 evicted by the fifth tag
        add_entry(32'h0000_02a8, 4'h0, 4'h6, 32'ha5c3_3c5a, 1'b0);
        add_entry(32'h0000_02a8, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_02bc, 4'h0, 4'h8, 32'h7700_0000, 1'b1);
        add_entry(32'h0000_02bc, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        add_entry(32'h0000_04a0, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_06a0, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_08a0, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_0aa4, 4'h0, 4'h1, 32'h0000_00e1, 1'b0);
        add_entry(32'h0000_0aa4, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
        // written-back line comes back from memory
        add_entry(32'h0000_02a8, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_06a0, 4'h0, 4'hf, 32'h0bad_f00d, 1'b1);
        // set 15 sits at the top of the modelled range
        add_entry(32'h0000_ffe0, 4'hf, 4'h0, 32'h0000_0000, 1'b0);
        add_entry(32'h0000_fffc, 4'hf, 4'h0, 32'h0000_0000, 1'b1);
    endtask

    // drive one request, wait for ufp_resp, check and update the shadow
    task automatic apply_entry(input int idx, input stim_t s);
        int          cycles;
        logic [31:0] expected;
        logic [13:0] widx;

        widx    = s.addr[15:2];
        ufp_req = '{addr: s.addr, rmask: s.rmask, wmask: s.wmask, wdata: s.wdata};
        cycles  = 0;
        @(negedge clk);
        while (!ufp_resp) begin
            cycles++;
            @(negedge clk);
        end

        assert (cycles > 0) else
            report_failure($sformatf("entry %0d responded in the cycle it was applied", idx));
        if (s.exp_hit) begin
            assert (cycles == 1) else report_failure($sformatf(
                "entry %0d at %h expected a hit but took %0d cycles", idx, s.addr, cycles));
        end else begin
            assert (cycles > 1) else report_failure($sformatf(
                "entry %0d at %h expected a miss but responded as a hit", idx, s.addr));
        end

        if (|s.rmask) begin
            for (int b = 0; b < 4; b++) begin
                expected[8*b +: 8] = s.rmask[b] ? shadow[widx][8*b +: 8] : 8'h00;
            end
            assert (ufp_rdata == expected) else report_failure($sformatf(
                "Error: ufp_rdata entry %0d addr %h got %h expected %h",
                idx, s.addr, ufp_rdata, expected));
        end
        if (|s.wmask) begin
            for (int b = 0; b < 4; b++) begin
                if (s.wmask[b]) begin
                    shadow[widx][8*b +: 8] = s.wdata[8*b +: 8];
                end
            end
            dirty_line[s.addr[15:5]] = 1'b1;
        end

        @(posedge clk);
        #1;
        ufp_req = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main flow
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        reset   = 1'b1;
        ufp_req = '0;
        for (int i = 0; i < 16384; i++) begin
            shadow[i] = {i[29:0], 2'b00} ^ 32'h5a5a_0000;
        end
        for (int i = 0; i < 2048; i++) begin
            dirty_line[i] = 1'b0;
        end
        load_table();
        table_loaded = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (!ufp_resp && !dfp_req.read && !dfp_req.write) else
            report_failure($sformatf(
                "Error: after reset ufp_resp %h dfp_req.read %h dfp_req.write %h",
                ufp_resp, dfp_req.read, dfp_req.write));
        @(posedge clk);
        #1;

        for (int i = 0; i < stim_table.size(); i++) begin
            apply_entry(i, stim_table[i]);
        end

        if (mem_fault) begin
            report_failure("memory model flagged a bad memory request or write-back");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    initial begin : fault_watch
        wait (mem_fault === 1'b1);
        report_failure("memory model flagged a bad memory request or write-back");
    end

    // budget per table entry plus reset
    initial begin : watchdog
        wait (table_loaded === 1'b1);
        repeat (stim_table.size() * cycle_budget + reset_cycles + 2) @(posedge clk);
        report_failure("timeout: the cache stopped responding within the cycle budget");
    end

endmodule
